//--- hist_params_pkg.sv
`default_nettype none

package hist_params_pkg;

    // bin address width, 2**DEF_NB bins per pixel histogram
    localparam int DEF_NB = 4;

    // width of one bin counter
    localparam int DEF_COUNT_W = 8;

    // photons per pixel before the pixel index moves on
    localparam int DEF_DATA_NUM = 3;

    // pixels sharing one count memory
    localparam int DEF_PIXEL_NUM = 2;

    // full pixel sweeps per frame
    localparam int DEF_ACQ_NUM = 2;

    // so one frame is DATA_NUM * PIXEL_NUM * ACQ_NUM writes

endpackage : hist_params_pkg

`default_nettype wire

//--- hist_types_pkg.sv
`default_nettype none

package hist_types_pkg;

    // frame type, alternates every frame
    // coarse pass comes first after reset
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } hist_pass_e;

endpackage : hist_types_pkg

`default_nettype wire

//--- pixel_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_sequencer #(
    parameter int DATA_NUM  = hist_params_pkg::DEF_DATA_NUM,
    parameter int PIXEL_NUM = hist_params_pkg::DEF_PIXEL_NUM,
    parameter int ACQ_NUM   = hist_params_pkg::DEF_ACQ_NUM,
    localparam int PIX_W    = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wr_en,
    output logic [PIX_W-1:0] pixel_idx,
    output logic             frame_last,
    output logic             last_acq
);

    // counter widths, at least one bit each
    localparam int DATA_W = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W  = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    // single acquisition per frame keeps last_acq up for good
    localparam logic LAST_ACQ_RST = (ACQ_NUM == 1);

    logic [DATA_W-1:0] photon_cnt;
    logic [ACQ_W-1:0]  acq_cnt;

    logic photon_last;
    logic pixel_last;
    logic acq_last;
    logic acq_pre_last;
    logic sweep_end;

    // wrap points of the three counters
    assign photon_last = (photon_cnt == DATA_W'(DATA_NUM - 1));
    assign pixel_last  = (pixel_idx == PIX_W'(PIXEL_NUM - 1));
    assign acq_last    = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    // acquisition just before the final one
    assign acq_pre_last = (ACQ_NUM > 1) && (acq_cnt == ACQ_W'(ACQ_NUM - 2));

    // write that closes a full pixel sweep
    assign sweep_end = wr_en && photon_last && pixel_last;

    // final write of the frame, combinational on purpose
    // memory and tracker register it themselves
    assign frame_last = sweep_end && acq_last;

    // nested counters, all step on wr_en only
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            photon_cnt <= '0;
            pixel_idx  <= '0;
            acq_cnt    <= '0;
        end else if (wr_en) begin
            if (photon_last) begin
                photon_cnt <= '0;
                if (pixel_last) begin
                    pixel_idx <= '0;
                    // acquisition wraps with the frame
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pixel_idx <= pixel_idx + 1'b1;
                end
            end else begin
                photon_cnt <= photon_cnt + 1'b1;
            end
        end
    end

    // final acquisition window
    // rises after the last write of acquisition ACQ_NUM-2
    // falls after frame_last
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            last_acq <= LAST_ACQ_RST;
        end else if (sweep_end) begin
            if (acq_last) begin
                last_acq <= LAST_ACQ_RST;
            end else if (acq_pre_last) begin
                last_acq <= 1'b1;
            end
        end
    end

endmodule : pixel_sequencer

`default_nettype wire

//--- bin_count_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bin_count_memory #(
    parameter int NB        = hist_params_pkg::DEF_NB,
    parameter int COUNT_W   = hist_params_pkg::DEF_COUNT_W,
    parameter int PIXEL_NUM = hist_params_pkg::DEF_PIXEL_NUM,
    localparam int PIX_W    = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wr_en,
    input  logic [NB-1:0]      addr,
    input  logic [PIX_W-1:0]   pixel_idx,
    input  logic               frame_last,
    output logic [COUNT_W-1:0] bin_count,
    output logic               count_valid
);

    // one histogram of 2**NB bins per pixel
    localparam int BINS   = 1 << NB;
    localparam int DEPTH  = PIXEL_NUM * BINS;
    localparam int ADDR_W = PIX_W + NB;

    logic [COUNT_W-1:0] count_mem [DEPTH];
    // entry written in the current frame
    logic [DEPTH-1:0]   valid_bits;

    logic [ADDR_W-1:0]  mem_addr;
    logic [COUNT_W-1:0] cur_count;
    logic [COUNT_W-1:0] new_count;
    logic               entry_valid;
    logic               clear_pend;

    // pixel_idx * BINS + addr
    assign mem_addr = {pixel_idx, addr};

    assign cur_count = count_mem[mem_addr];

    // old frame contents are dead in the clear cycle already
    assign entry_valid = valid_bits[mem_addr] && !clear_pend;

    // stale entry restarts at 1, otherwise saturating increment
    always_comb begin
        if (!entry_valid) begin
            new_count = COUNT_W'(1);
        end else if (&cur_count) begin
            new_count = cur_count;
        end else begin
            new_count = cur_count + 1'b1;
        end
    end

    // count array, read and written in the same cycle
    // a repeat write next cycle sees the stored value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            count_mem[mem_addr] <= new_count;
        end
    end

    // flash clear one cycle after frame_last
    // a write in that cycle keeps its own bit
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            clear_pend <= 1'b0;
            valid_bits <= '0;
        end else begin
            clear_pend <= frame_last;
            if (clear_pend) begin
                valid_bits <= '0;
            end
            if (wr_en) begin
                valid_bits[mem_addr] <= 1'b1;
            end
        end
    end

    // updated count out one cycle after the write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_count   <= '0;
            count_valid <= 1'b0;
        end else begin
            count_valid <= wr_en;
            if (wr_en) begin
                bin_count <= new_count;
            end
        end
    end

endmodule : bin_count_memory

`default_nettype wire

//--- peak_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module peak_tracker #(
    parameter int NB        = hist_params_pkg::DEF_NB,
    parameter int COUNT_W   = hist_params_pkg::DEF_COUNT_W,
    parameter int PIXEL_NUM = hist_params_pkg::DEF_PIXEL_NUM,
    localparam int PIX_W    = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       count_valid,
    input  logic [COUNT_W-1:0]         bin_count,
    input  logic [NB-1:0]              addr,
    input  logic [PIX_W-1:0]           pixel_idx,
    input  logic                       frame_last,
    output hist_types_pkg::hist_pass_e his_num,
    output logic [NB-1:0]              peak_ch,
    output logic [NB-1:0]              peak_fh,
    output logic [PIX_W-1:0]           peak_pixel,
    output logic                       peak_done
);

    import hist_types_pkg::*;

    // write-side info, one cycle late to line up with bin_count
    logic [NB-1:0]      addr_d;
    logic [PIX_W-1:0]   pixel_d;
    logic               frame_last_d;

    // running maximum of the current frame
    logic [COUNT_W-1:0] max_count;
    logic [NB-1:0]      max_bin;
    logic [PIX_W-1:0]   max_pixel;

    logic               take_new;
    logic [NB-1:0]      win_bin;
    logic [PIX_W-1:0]   win_pixel;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            addr_d       <= '0;
            pixel_d      <= '0;
            frame_last_d <= 1'b0;
        end else begin
            addr_d       <= addr;
            pixel_d      <= pixel_idx;
            frame_last_d <= frame_last;
        end
    end

    // strictly greater only, so a tie keeps the earlier bin
    assign take_new = count_valid && (bin_count > max_count);

    // winner includes the count arriving this cycle
    assign win_bin   = take_new ? addr_d : max_bin;
    assign win_pixel = take_new ? pixel_d : max_pixel;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            max_count <= '0;
            max_bin   <= '0;
            max_pixel <= '0;
        end else if (frame_last_d) begin
            // next frame starts from scratch
            max_count <= '0;
            max_bin   <= '0;
            max_pixel <= '0;
        end else if (take_new) begin
            max_count <= bin_count;
            max_bin   <= addr_d;
            max_pixel <= pixel_d;
        end
    end

    // frame end, two cycles after the last write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            his_num    <= PASS_COARSE;
            peak_ch    <= '0;
            peak_fh    <= '0;
            peak_pixel <= '0;
            peak_done  <= 1'b0;
        end else begin
            peak_done <= frame_last_d;
            if (frame_last_d) begin
                // peak goes to the output of the pass just finished
                if (his_num == PASS_COARSE) begin
                    peak_ch <= win_bin;
                    his_num <= PASS_FINE;
                end else begin
                    peak_fh <= win_bin;
                    his_num <= PASS_COARSE;
                end
                peak_pixel <= win_pixel;
            end
        end
    end

endmodule : peak_tracker

`default_nettype wire

//--- hist_builder_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_top #(
    parameter int NB        = hist_params_pkg::DEF_NB,
    parameter int COUNT_W   = hist_params_pkg::DEF_COUNT_W,
    parameter int DATA_NUM  = hist_params_pkg::DEF_DATA_NUM,
    parameter int PIXEL_NUM = hist_params_pkg::DEF_PIXEL_NUM,
    parameter int ACQ_NUM   = hist_params_pkg::DEF_ACQ_NUM,
    localparam int PIX_W    = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       wr_en,
    input  logic [NB-1:0]              addr,
    output logic [COUNT_W-1:0]         bin_count,
    output logic                       count_valid,
    output logic                       last_acq,
    output hist_types_pkg::hist_pass_e his_num,
    output logic [NB-1:0]              peak_ch,
    output logic [NB-1:0]              peak_fh,
    output logic [PIX_W-1:0]           peak_pixel,
    output logic                       peak_done
);

    // pixel index shared by memory and tracker
    logic [PIX_W-1:0] pixel_idx;
    // last write of the frame, combinational
    logic             frame_last;

    // photon / pixel / acquisition counting
    pixel_sequencer #(
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wr_en      (wr_en),
        .pixel_idx  (pixel_idx),
        .frame_last (frame_last),
        .last_acq   (last_acq)
    );

    // per-bin counts, one cycle latency
    bin_count_memory #(
        .NB        (NB),
        .COUNT_W   (COUNT_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) u_memory (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .addr        (addr),
        .pixel_idx   (pixel_idx),
        .frame_last  (frame_last),
        .bin_count   (bin_count),
        .count_valid (count_valid)
    );

    // tracker sees raw addr and pixel, aligns them internally
    peak_tracker #(
        .NB        (NB),
        .COUNT_W   (COUNT_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) u_tracker (
        .clk         (clk),
        .combin_res  (combin_res),
        .count_valid (count_valid),
        .bin_count   (bin_count),
        .addr        (addr),
        .pixel_idx   (pixel_idx),
        .frame_last  (frame_last),
        .his_num     (his_num),
        .peak_ch     (peak_ch),
        .peak_fh     (peak_fh),
        .peak_pixel  (peak_pixel),
        .peak_done   (peak_done)
    );

endmodule : hist_builder_top

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic combin_res
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset low over the first 4 rising edges, released just after
    initial begin
        combin_res = 1'b0;
        repeat (4) @(posedge clk);
        #1 combin_res = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- hist_builder_sva.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_sva (
    input logic                       clk,
    input logic                       combin_res,
    input logic                       wr_en,
    input logic                       count_valid,
    input logic                       last_acq,
    input hist_types_pkg::hist_pass_e his_num,
    input logic                       peak_done
);

    // failed properties so far, looked up by the testbench
    int assert_fails = 0;

    // single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!combin_res)
        peak_done |=> !peak_done)
        else begin
            $error("peak_done stayed high for more than one cycle");
            assert_fails++;
        end

    // memory latency is exactly one cycle
    valid_follows_write: assert property (@(posedge clk) disable iff (!combin_res)
        count_valid == $past(wr_en))
        else begin
            $error("count_valid does not follow wr_en by one cycle");
            assert_fails++;
        end

    // pass flips only at the frame-end pulse
    pass_flip_on_done: assert property (@(posedge clk) disable iff (!combin_res)
        (his_num != $past(his_num)) |-> peak_done)
        else begin
            $error("his_num changed without peak_done");
            assert_fails++;
        end

    // window opens on a write only
    last_acq_needs_write: assert property (@(posedge clk) disable iff (!combin_res)
        (last_acq && !$past(last_acq)) |-> $past(wr_en))
        else begin
            $error("last_acq rose without a write in the cycle before");
            assert_fails++;
        end

endmodule : hist_builder_sva

bind hist_builder_top hist_builder_sva u_sva (.*);

`default_nettype wire

//--- hist_builder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hist_builder_tb;

    import hist_params_pkg::*;
    import hist_types_pkg::*;

    localparam int NB      = DEF_NB;
    localparam int COUNT_W = DEF_COUNT_W;
    localparam int PIX_W   = (DEF_PIXEL_NUM > 1) ? $clog2(DEF_PIXEL_NUM) : 1;
    localparam int CNT_MAX = (1 << COUNT_W) - 1;
    // writes per frame
    localparam int WPF     = DEF_DATA_NUM * DEF_PIXEL_NUM * DEF_ACQ_NUM;

    logic clk, combin_res, wr_en, count_valid, last_acq, peak_done;
    logic [NB-1:0] addr, peak_ch, peak_fh;
    logic [COUNT_W-1:0] bin_count;
    logic [PIX_W-1:0] peak_pixel;
    hist_pass_e his_num;

    // reference model state for counts, counters and the first-reaching max
    int cnt_ref [DEF_PIXEL_NUM][1 << NB];
    int photon_ref, pixel_ref, acq_ref, done_due, pend_bin, pend_pix;
    int max_cnt, max_bin, max_pix, ch_ref, fh_ref, pix_ref, first_bin;
    hist_pass_e pass_ref = PASS_COARSE;
    logic acq_ref_lvl = (DEF_ACQ_NUM == 1);
    int seed = 32'ha01b_8256;
    int err_cnt, check_cnt, tests_run;

    tb_clock_gen u_clk_gen (
        .clk        (clk),
        .combin_res (combin_res)
    );

    hist_builder_top #(
        .NB        (DEF_NB),
        .COUNT_W   (DEF_COUNT_W),
        .DATA_NUM  (DEF_DATA_NUM),
        .PIXEL_NUM (DEF_PIXEL_NUM),
        .ACQ_NUM   (DEF_ACQ_NUM)
    ) UUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .addr        (addr),
        .bin_count   (bin_count),
        .count_valid (count_valid),
        .last_acq    (last_acq),
        .his_num     (his_num),
        .peak_ch     (peak_ch),
        .peak_fh     (peak_fh),
        .peak_pixel  (peak_pixel),
        .peak_done   (peak_done)
    );

    task automatic check_value(input string name, input int got, input int exp);
        check_cnt++;
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got 'h%0h, expected 'h%0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // peak side and last_acq compared with the model every cycle
    task automatic check_outputs(input logic done_now);
        check_value("peak_done", int'(peak_done), int'(done_now));
        check_value("his_num", int'(his_num), int'(pass_ref));
        check_value("peak_ch", int'(peak_ch), ch_ref);
        check_value("peak_fh", int'(peak_fh), fh_ref);
        check_value("peak_pixel", int'(peak_pixel), pix_ref);
        check_value("last_acq", int'(last_acq), int'(acq_ref_lvl));
    endtask

    // drive one cycle and update the model, then check after the next edge
    task automatic drive_cycle(input logic we, input logic [NB-1:0] a);
        int exp_cnt;
        logic done_now;
        exp_cnt = 0;
        done_now = 1'b0;
        wr_en = we;
        addr = a;
        if (we) begin
            exp_cnt = cnt_ref[pixel_ref][int'(a)];
            exp_cnt = (exp_cnt < CNT_MAX) ? exp_cnt + 1 : exp_cnt;
            cnt_ref[pixel_ref][int'(a)] = exp_cnt;
            // ties keep the earlier bin
            if (exp_cnt > max_cnt) begin
                max_cnt = exp_cnt;
                max_bin = int'(a);
                max_pix = pixel_ref;
            end
            photon_ref = (photon_ref + 1) % DEF_DATA_NUM;
            if (photon_ref == 0) begin
                pixel_ref = (pixel_ref + 1) % DEF_PIXEL_NUM;
            end
            if (photon_ref == 0 && pixel_ref == 0) begin
                acq_ref = (acq_ref + 1) % DEF_ACQ_NUM;
                if (acq_ref == DEF_ACQ_NUM - 1) begin
                    acq_ref_lvl = 1'b1;
                end
                // winner of the frame shows up two cycles later
                if (acq_ref == 0) begin
                    acq_ref_lvl = (DEF_ACQ_NUM == 1);
                    done_due = 2;
                    pend_bin = max_bin;
                    pend_pix = max_pix;
                    max_cnt = 0;
                    foreach (cnt_ref[p, b]) begin
                        cnt_ref[p][b] = 0;
                    end
                end
            end
        end
        @(posedge clk);
        #1;
        if (done_due > 0) begin
            done_due--;
            if (done_due == 0) begin
                done_now = 1'b1;
                pix_ref = pend_pix;
                if (pass_ref == PASS_COARSE) begin
                    ch_ref = pend_bin;
                    pass_ref = PASS_FINE;
                end else begin
                    fh_ref = pend_bin;
                    pass_ref = PASS_COARSE;
                end
            end
        end
        check_value("count_valid", int'(count_valid), int'(we));
        if (we) begin
            check_value("bin_count", int'(bin_count), exp_cnt);
        end
        check_outputs(done_now);
    endtask

    // one frame of writes with idle lead-in, random gaps and same-bin repeats
    task automatic run_frame(input int lead, input int first_addr, input logic flush);
        logic [NB-1:0] a;
        int waited;
        waited = 0;
        a = NB'(first_addr);
        first_bin = int'(a);
        repeat (lead) begin
            drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b1, a);
        // second photon always hits the first bin back-to-back
        drive_cycle(1'b1, a);
        repeat (WPF - 2) begin
            // about a quarter repeat the previous bin back-to-back
            if (($random(seed) & 3) != 0) begin
                a = NB'($random(seed));
                if (($random(seed) & 3) == 0) begin
                    drive_cycle(1'b0, '0);
                end
            end
            drive_cycle(1'b1, a);
        end
        while (flush && !peak_done && waited < 8) begin
            drive_cycle(1'b0, '0);
            waited++;
        end
        if (flush && !peak_done) begin
            $display("timeout: no peak_done after the last write of the frame");
            err_cnt++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int waited;
        int errs;
        wr_en = 1'b0;
        addr = '0;
        waited = 0;
        while (combin_res !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        #1;
        errs = err_cnt;
        if (combin_res !== 1'b1) begin
            $display("timeout: reset was never released");
            err_cnt++;
        end
        check_value("count_valid", int'(count_valid), 0);
        check_value("bin_count", int'(bin_count), 0);
        check_outputs(1'b0);
        report_test(1, "reset values", errs);
        errs = err_cnt;
        run_frame(0, 5, 1'b1);
        report_test(2, "coarse frame counts and peak", errs);
        errs = err_cnt;
        run_frame(2, first_bin, 1'b1);
        report_test(3, "fine frame, old bin after a gap", errs);
        errs = err_cnt;
        run_frame(1, $random(seed), 1'b0);
        run_frame(0, first_bin, 1'b1);
        report_test(4, "old bin written right after frame end", errs);
        errs = err_cnt;
        run_frame(3, $random(seed), 1'b1);
        run_frame(1, $random(seed), 1'b1);
        report_test(5, "last_acq window over two gapped frames", errs);
        $display("summary: %0d tests, %0d checks, %0d check errors, %0d assertion errors",
            tests_run, check_cnt, err_cnt, UUT.u_sva.assert_fails);
        if (err_cnt == 0 && UUT.u_sva.assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : hist_builder_tb

`default_nettype wire

//--- compile.f
hist_params_pkg.sv
hist_types_pkg.sv
pixel_sequencer.sv
bin_count_memory.sv
peak_tracker.sv
hist_builder_top.sv
tb_clock_gen.sv
hist_builder_sva.sv
hist_builder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
out=""
verilator --binary --timing --assert --top-module hist_builder_tb -f compile.f \
    && out=$(./obj_dir/Vhist_builder_tb +verilator+error+limit+100) \
    ; printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -qx "all tests passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
